/* soc_bus.f */
src/bus_pkg.sv
src/map_pkg.sv
src/addr_decoder.sv
src/bus_arbiter.sv
src/cpu_ram.sv
src/flash_reader.sv
src/dma_fill.sv
src/video_regs.sv
src/soc_bus_top.sv
testbench/soc_bus_checker.sv
testbench/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SoC bus regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim
./obj_dir/soc_bus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
else
    exit 1
fi

/* testbench/soc_bus_tb.sv */
//**********************************************************************
// SoC bus testbench
// drives the CPU bus, pad and DMA of the top level and reports
// per test results from the checker
//**********************************************************************
`timescale 1ns/1ps

module soc_bus_tb;
    import bus_pkg::*;

    localparam int ram_tests    = 16;
    localparam int flash_tests  = 8;
    localparam int vdp_tests    = 4;
    localparam int pad_tests    = 4;
    localparam int max_dma_len  = 32;
    localparam int access_total = 3 * ram_tests + flash_tests + 2 * vdp_tests + pad_tests
                                  + max_dma_len + 1;
    localparam int timeout_limit = access_total * 20 + 2 * max_dma_len + 20;

    logic      clk;
    logic      arst_n;
    logic      cpu_valid;
    cpu_addr_t cpu_address;
    wstrb_t    cpu_wstrb;
    data_t     cpu_write_data;
    logic      cpu_mem_ready;
    data_t     cpu_read_data;
    pad_t      pad_in;
    logic      dma_start;
    ram_addr_t dma_dest;
    dma_len_t  dma_len;
    data_t     dma_seed;
    logic      dma_busy;

    logic [31:0] rng_state;
    cpu_addr_t   ram_list [ram_tests];
    int          checks;
    int          errors;
    int          mark_checks = 0;
    int          mark_errors = 0;
    int          cycle_count = 0;

    always #20 clk = ~clk;

    soc_bus_top DUT (
        .clk(clk), .arst_n(arst_n),
        .cpu_valid(cpu_valid), .cpu_address(cpu_address), .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data), .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data), .pad_in(pad_in),
        .dma_start(dma_start), .dma_dest(dma_dest), .dma_len(dma_len),
        .dma_seed(dma_seed), .dma_busy(dma_busy)
    );

    soc_bus_checker u_checker (
        .clk(clk), .arst_n(arst_n),
        .cpu_valid(cpu_valid), .cpu_address(cpu_address), .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data), .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data), .pad_in(pad_in),
        .dma_start(dma_start), .dma_dest(dma_dest), .dma_len(dma_len),
        .dma_seed(dma_seed), .dma_busy(dma_busy),
        .check_count(checks), .error_count(errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // holds the request until ready, then one idle cycle
    task automatic cpu_access(input cpu_addr_t addr, input wstrb_t strb, input data_t data);
        cpu_valid      <= 1'b1;
        cpu_address    <= addr;
        cpu_wstrb      <= strb;
        cpu_write_data <= data;
        @(posedge clk);
        while (!cpu_mem_ready) begin
            @(posedge clk);
        end
        cpu_valid <= 1'b0;
        @(posedge clk);
    endtask

    // returns one edge after start, with busy already high
    task automatic run_dma(input ram_addr_t dest, input dma_len_t len, input data_t seed);
        dma_start <= 1'b1;
        dma_dest  <= dest;
        dma_len   <= len;
        dma_seed  <= seed;
        @(posedge clk);
        dma_start <= 1'b0;
        @(posedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, an access or DMA never finished", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        wstrb_t      strb;
        dma_len_t    len;
        ram_addr_t   dest;
        ram_addr_t   word;
        clk            = 1'b0;
        arst_n         = 1'b0;
        cpu_valid      = 1'b0;
        cpu_address    = '0;
        cpu_wstrb      = '0;
        cpu_write_data = '0;
        pad_in         = '0;
        dma_start      = 1'b0;
        dma_dest       = '0;
        dma_len        = '0;
        dma_seed       = '0;
        rng_state      = 32'd25;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // full words first so every byte is known
        for (int i = 0; i < ram_tests; i++) begin
            r = next_random();
            ram_list[i] = {2'b00, r[11:0], 2'b00};
            cpu_access(ram_list[i], 4'hF, next_random());
        end
        for (int i = 0; i < ram_tests; i++) begin
            r    = next_random();
            strb = wstrb_t'(r[3:0]);
            if (strb == '0) begin
                strb = 4'b1010;
            end
            cpu_access(ram_list[i], strb, next_random());
        end
        for (int i = 0; i < ram_tests; i++) begin
            cpu_access(ram_list[i], '0, '0);
        end
        report_test("ram strobes");

        for (int i = 0; i < flash_tests; i++) begin
            r = next_random();
            cpu_access({2'b10, r[11:0], 2'b00}, '0, '0);
        end
        report_test("flash read");

        for (int i = 0; i < vdp_tests; i++) begin
            cpu_access(cpu_addr_t'(16'hC000 + i * 4), 4'hF, next_random());
        end
        for (int i = 0; i < vdp_tests; i++) begin
            cpu_access(cpu_addr_t'(16'hC000 + i * 4), '0, '0);
        end
        for (int i = 0; i < pad_tests; i++) begin
            r = next_random();
            pad_in <= r[1:0];
            cpu_access(16'hE000, '0, '0);
        end
        report_test("video and pad");

        // fill lands above the words used by the ram test
        r    = next_random();
        len  = dma_len_t'(8 + (r % 24));
        dest = ram_addr_t'(14'h1000 + r[17:8]);
        run_dma(dest, len, next_random());
        while (dma_busy) begin
            @(posedge clk);
        end
        for (int k = 0; k < int'(len); k++) begin
            word = dest + ram_addr_t'(k);
            cpu_access({word, 2'b00}, '0, '0);
        end
        report_test("dma fill");

        // read stalls behind a second burst
        r = next_random();
        run_dma(ram_addr_t'(14'h1800 + r[9:0]), dma_len_t'(8 + (r[31:16] % 24)), next_random());
        cpu_access(ram_list[0], '0, '0);
        while (dma_busy) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        report_test("dma stall");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* testbench/soc_bus_checker.sv */
//**********************************************************************
// SoC bus checker
// watches the top level ports, keeps shadow RAM and video registers,
// and compares every CPU read and ready timing against them
//**********************************************************************
`timescale 1ns/1ps

module soc_bus_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cpu_valid,
    input  bus_pkg::cpu_addr_t cpu_address,
    input  bus_pkg::wstrb_t    cpu_wstrb,
    input  bus_pkg::data_t     cpu_write_data,
    input  logic               cpu_mem_ready,
    input  bus_pkg::data_t     cpu_read_data,
    input  bus_pkg::pad_t      pad_in,
    input  logic               dma_start,
    input  bus_pkg::ram_addr_t dma_dest,
    input  bus_pkg::dma_len_t  dma_len,
    input  bus_pkg::data_t     dma_seed,
    input  logic               dma_busy,
    output int                 check_count,
    output int                 error_count
);
    import bus_pkg::*;
    import map_pkg::*;

    data_t     shadow_ram [ram_words];
    vdp_data_t shadow_vdp [vdp_reg_count];
    logic      pending;
    logic      ready_q;
    cpu_addr_t acc_addr;
    wstrb_t    acc_strb;
    data_t     acc_data;
    int        live_cycles;
    int        busy_cycles;
    logic      dma_armed;
    ram_addr_t dma_ptr;
    data_t     dma_val;
    dma_len_t  dma_len_q;

    function automatic bit is_ram(input cpu_addr_t addr);
        return !addr[15];
    endfunction

    function automatic bit is_pad(input cpu_addr_t addr);
        return (addr[15:14] == region_io) && addr[13];
    endfunction

    // cycles from the first non-stalled edge of valid to the ready sample
    function automatic int expected_latency(input cpu_addr_t addr);
        if (is_ram(addr) || is_pad(addr)) begin
            return 1;
        end
        if (addr[15:14] == region_flash) begin
            return flash_wait + 1;
        end
        return 2;
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t wdata,
                                          input wstrb_t strb);
        data_t m;
        m = old;
        for (int b = 0; b < wstrb_w; b++) begin
            if (strb[b]) begin
                m[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return m;
    endfunction

    function automatic data_t expected_read(input cpu_addr_t addr);
        if (is_ram(addr)) begin
            return shadow_ram[addr[15:2]];
        end
        if (addr[15:14] == region_flash) begin
            return {20'd0, addr[13:2]} ^ 32'hA5A5_0000;
        end
        // video word seen on both halves
        return {2{shadow_vdp[addr[3:2]]}};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending     = 1'b0;
            ready_q     = 1'b0;
            busy_cycles = 0;
            dma_armed   = 1'b0;
            check_count = 0;
            error_count = 0;
            for (int i = 0; i < vdp_reg_count; i++) begin
                shadow_vdp[i] = '0;
            end
        end else begin
            if (cpu_mem_ready) begin
                if (ready_q) begin
                    error_count++;
                    $display("ready held high for more than one cycle at %0t", $time);
                end else if (!pending) begin
                    error_count++;
                    $display("ready seen at %0t while no access was pending", $time);
                end else begin
                    pending = 1'b0;
                    check_count++;
                    if (live_cycles != expected_latency(acc_addr)) begin
                        error_count++;
                        $display("Error at %0t: ready for %h after %0d cycles, expected %0d",
                                 $time, acc_addr, live_cycles, expected_latency(acc_addr));
                    end
                    if (acc_strb == '0 && is_pad(acc_addr)) begin
                        if (cpu_read_data[1:0] !== pad_in) begin
                            error_count++;
                            $display("Error at %0t: pad read got %b, expected %b",
                                     $time, cpu_read_data[1:0], pad_in);
                        end
                    end else if (acc_strb == '0) begin
                        if (cpu_read_data !== expected_read(acc_addr)) begin
                            error_count++;
                            $display("Error at %0t: read of %h got %h, expected %h",
                                     $time, acc_addr, cpu_read_data, expected_read(acc_addr));
                        end
                    end else if (is_ram(acc_addr)) begin
                        shadow_ram[acc_addr[15:2]] =
                            merge_bytes(shadow_ram[acc_addr[15:2]], acc_data, acc_strb);
                    end else begin
                        shadow_vdp[acc_addr[3:2]] = acc_data[15:0];
                    end
                end
            end else if (pending) begin
                // a DMA burst stalls the access
                if (!dma_busy) begin
                    live_cycles++;
                end
            end else if (cpu_valid) begin
                pending     = 1'b1;
                acc_addr    = cpu_address;
                acc_strb    = cpu_wstrb;
                acc_data    = cpu_write_data;
                live_cycles = dma_busy ? 0 : 1;
            end
            ready_q = cpu_mem_ready;

            // fill words are seed plus index
            if (dma_busy) begin
                shadow_ram[dma_ptr] = dma_val;
                dma_ptr             = dma_ptr + ram_addr_t'(1);
                dma_val             = dma_val + 32'd1;
                busy_cycles++;
            end else begin
                // busy is due on the edge after start
                if (busy_cycles != 0 || dma_armed) begin
                    check_count++;
                    if (busy_cycles != int'(dma_len_q)) begin
                        error_count++;
                        $display("Error at %0t: DMA busy for %0d cycles, expected %0d",
                                 $time, busy_cycles, dma_len_q);
                    end
                    busy_cycles = 0;
                    dma_armed   = 1'b0;
                end
                if (dma_start) begin
                    dma_ptr   = dma_dest;
                    dma_val   = dma_seed;
                    dma_len_q = dma_len;
                    dma_armed = 1'b1;
                end
            end
        end
    end

endmodule

/* src/soc_bus_top.sv */
//*********************************************************************
// SoC memory bus top level
// CPU port and fill DMA sharing one RAM, plus flash, video and pad
//*********************************************************************
`timescale 1ns/1ps

module soc_bus_top (
    input  logic               clk,
    input  logic               arst_n,

    // cpu bus
    input  logic               cpu_valid,
    input  bus_pkg::cpu_addr_t cpu_address,
    input  bus_pkg::wstrb_t    cpu_wstrb,
    input  bus_pkg::data_t     cpu_write_data,
    output logic               cpu_mem_ready,
    output bus_pkg::data_t     cpu_read_data,

    input  bus_pkg::pad_t      pad_in,

    // dma control
    input  logic               dma_start,
    input  bus_pkg::ram_addr_t dma_dest,
    input  bus_pkg::dma_len_t  dma_len,
    input  bus_pkg::data_t     dma_seed,
    output logic               dma_busy
);
    import bus_pkg::*;

    logic      ram_en;
    logic      flash_read_en;
    logic      vdp_en;
    logic      pad_en;
    logic      flash_read_ready;
    logic      vdp_ready;
    data_t     ram_read_data;
    data_t     flash_read_data;
    vdp_data_t vdp_read_data;
    ram_addr_t dma_address;
    wstrb_t    dma_wstrb;
    data_t     dma_write_data;
    data_t     ram_write_data;
    ram_addr_t ram_address;
    wstrb_t    ram_wstrb;
    logic      ram_cs;

    addr_decoder u_decoder (
        .cpu_valid     (cpu_valid),
        .cpu_address   (cpu_address),
        .ram_en        (ram_en),
        .flash_read_en (flash_read_en),
        .vdp_en        (vdp_en),
        .pad_en        (pad_en)
    );

    // pad input is read directly through the arbiter
    bus_arbiter u_arbiter (
        .clk              (clk),
        .arst_n           (arst_n),
        .cpu_wstrb        (cpu_wstrb),
        .cpu_address      (cpu_address),
        .cpu_write_data   (cpu_write_data),
        .dma_address      (dma_address),
        .dma_write_data   (dma_write_data),
        .dma_busy         (dma_busy),
        .dma_wstrb        (dma_wstrb),
        .ram_en           (ram_en),
        .flash_read_en    (flash_read_en),
        .vdp_en           (vdp_en),
        .pad_en           (pad_en),
        .flash_read_ready (flash_read_ready),
        .vdp_ready        (vdp_ready),
        .ram_read_data    (ram_read_data),
        .flash_read_data  (flash_read_data),
        .vdp_read_data    (vdp_read_data),
        .pad_read_data    (pad_in),
        .cpu_mem_ready    (cpu_mem_ready),
        .cpu_read_data    (cpu_read_data),
        .ram_write_data   (ram_write_data),
        .ram_address      (ram_address),
        .ram_wstrb        (ram_wstrb),
        .ram_cs           (ram_cs)
    );

    cpu_ram u_ram (
        .clk        (clk),
        .cs         (ram_cs),
        .address    (ram_address),
        .wstrb      (ram_wstrb),
        .write_data (ram_write_data),
        .read_data  (ram_read_data)
    );

    flash_reader u_flash (
        .clk        (clk),
        .arst_n     (arst_n),
        .read_en    (flash_read_en),
        .address    (cpu_address),
        .read_ready (flash_read_ready),
        .read_data  (flash_read_data)
    );

    video_regs u_video (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (vdp_en),
        .wstrb      (cpu_wstrb),
        .address    (cpu_address),
        .write_data (cpu_write_data),
        .ready      (vdp_ready),
        .read_data  (vdp_read_data)
    );

    dma_fill u_dma (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (dma_start),
        .dest       (dma_dest),
        .len        (dma_len),
        .seed       (dma_seed),
        .busy       (dma_busy),
        .address    (dma_address),
        .wstrb      (dma_wstrb),
        .write_data (dma_write_data)
    );

endmodule

/* src/video_regs.sv */
//*********************************************************************
// Video registers
// four 16-bit registers, ready one cycle after enable
//*********************************************************************
`timescale 1ns/1ps

module video_regs (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               en,
    input  bus_pkg::wstrb_t    wstrb,
    input  bus_pkg::cpu_addr_t address,
    input  bus_pkg::data_t     write_data,
    output logic               ready,
    output bus_pkg::vdp_data_t read_data
);
    import bus_pkg::*;
    import map_pkg::*;

    vdp_data_t            regs [vdp_reg_count];
    logic [vdp_sel_w-1:0] sel;

    // word select from bits 3:2
    assign sel = address[vdp_sel_w+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready     <= 1'b0;
            read_data <= '0;
            for (int i = 0; i < vdp_reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ready <= en;
            if (en) begin
                read_data <= regs[sel];
                // low half of the bus only
                if (wstrb != '0) begin
                    regs[sel] <= write_data[vdp_data_w-1:0];
                end
            end
        end
    end

endmodule

/* src/dma_fill.sv */
//*********************************************************************
// DMA fill engine
// writes a run of counting words into RAM, one word per cycle,
// holding busy for the length of the run
//*********************************************************************
`timescale 1ns/1ps

module dma_fill (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  bus_pkg::ram_addr_t dest,
    input  bus_pkg::dma_len_t  len,
    input  bus_pkg::data_t     seed,
    output logic               busy,
    output bus_pkg::ram_addr_t address,
    output bus_pkg::wstrb_t    wstrb,
    output bus_pkg::data_t     write_data
);
    import bus_pkg::*;
    import map_pkg::*;

    dma_state_t state;
    dma_len_t   remaining;
    ram_addr_t  addr_q;
    data_t      data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= dma_idle;
            remaining <= '0;
        end else begin
            case (state)
                dma_idle: begin
                    // zero length never leaves idle
                    if (start && (len != '0)) begin
                        state     <= dma_run;
                        remaining <= len;
                    end
                end
                dma_run: begin
                    remaining <= remaining - 1'b1;
                    if (remaining == dma_len_t'(1)) begin
                        state <= dma_idle;
                    end
                end
                default: state <= dma_idle;
            endcase
        end
    end

    // counters track the word written this cycle
    always_ff @(posedge clk) begin
        if (state == dma_idle) begin
            addr_q <= dest;
            data_q <= seed;
        end else begin
            addr_q <= addr_q + 1'b1;
            data_q <= data_q + 1'b1;
        end
    end

    assign busy       = (state == dma_run);
    assign address    = addr_q;
    assign write_data = data_q;
    // full words only
    assign wstrb      = busy ? '1 : '0;

endmodule

/* src/flash_reader.sv */
//*********************************************************************
// Flash reader
// read-only flash model, one word returned after a fixed wait
//*********************************************************************
`timescale 1ns/1ps

module flash_reader (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               read_en,
    input  bus_pkg::cpu_addr_t address,
    output logic               read_ready,
    output bus_pkg::data_t     read_data
);
    import bus_pkg::*;
    import map_pkg::*;

    logic                   en_q;
    logic                   start;
    logic                   pending;
    logic [flash_cnt_w-1:0] wait_cnt;

    // a new access is the rise of the enable
    assign start = read_en && !en_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_q       <= 1'b0;
            pending    <= 1'b0;
            wait_cnt   <= '0;
            read_ready <= 1'b0;
        end else begin
            en_q       <= read_en;
            read_ready <= 1'b0;
            if (start) begin
                pending  <= 1'b1;
                wait_cnt <= flash_cnt_w'(flash_wait - 1);
            end else if (pending) begin
                wait_cnt <= wait_cnt - 1'b1;
                // last wait cycle, one ready pulse per access
                if (wait_cnt == flash_cnt_w'(1)) begin
                    pending    <= 1'b0;
                    read_ready <= 1'b1;
                end
            end
        end
    end

    // contents are the word index within the flash window
    always_ff @(posedge clk) begin
        if (start) begin
            read_data <= data_t'(address[13:2]) ^ flash_pattern;
        end
    end

endmodule

/* src/cpu_ram.sv */
//*********************************************************************
// CPU RAM
// 16K x 32 word memory, byte strobed write, registered read
//*********************************************************************
`timescale 1ns/1ps

module cpu_ram (
    input  logic               clk,
    input  logic               cs,
    input  bus_pkg::ram_addr_t address,
    input  bus_pkg::wstrb_t    wstrb,
    input  bus_pkg::data_t     write_data,
    output bus_pkg::data_t     read_data
);
    import bus_pkg::*;

    data_t mem [ram_words];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (cs) begin
            for (int b = 0; b < wstrb_w; b++) begin
                if (wstrb[b]) begin
                    mem[address][b*8 +: 8] <= write_data[b*8 +: 8];
                end
            end
        end
    end

    // read returns the word as it was before a same-cycle write
    always_ff @(posedge clk) begin
        if (cs) begin
            read_data <= mem[address];
        end
    end

endmodule

/* src/bus_arbiter.sv */
//*********************************************************************
// Bus arbiter
// shares the RAM between DMA and CPU, builds the single ready pulse
// for the CPU and selects which source drives the read data
//*********************************************************************
`timescale 1ns/1ps

module bus_arbiter (
    input  logic               clk,
    input  logic               arst_n,

    // cpu request
    input  bus_pkg::wstrb_t    cpu_wstrb,
    input  bus_pkg::cpu_addr_t cpu_address,
    input  bus_pkg::data_t     cpu_write_data,

    // dma request
    input  bus_pkg::ram_addr_t dma_address,
    input  bus_pkg::data_t     dma_write_data,
    input  logic               dma_busy,
    input  bus_pkg::wstrb_t    dma_wstrb,

    // region enables from the decoder
    input  logic               ram_en,
    input  logic               flash_read_en,
    input  logic               vdp_en,
    input  logic               pad_en,

    // ready from the slow sources
    input  logic               flash_read_ready,
    input  logic               vdp_ready,

    // read sources
    input  bus_pkg::data_t     ram_read_data,
    input  bus_pkg::data_t     flash_read_data,
    input  bus_pkg::vdp_data_t vdp_read_data,
    input  bus_pkg::pad_t      pad_read_data,

    // back to the cpu
    output logic               cpu_mem_ready,
    output bus_pkg::data_t     cpu_read_data,

    // ram port
    output bus_pkg::data_t     ram_write_data,
    output bus_pkg::ram_addr_t ram_address,
    output bus_pkg::wstrb_t    ram_wstrb,
    output logic               ram_cs
);
    import bus_pkg::*;

    logic ram_ready;
    logic periph_ready;
    logic flash_en_q;

    // dma owns the ram outright while busy
    assign ram_cs         = dma_busy ? 1'b1 : ram_en;
    assign ram_wstrb      = dma_busy ? dma_wstrb : cpu_wstrb;
    assign ram_write_data = dma_busy ? dma_write_data : cpu_write_data;
    assign ram_address    = dma_busy ? dma_address : cpu_address[15:2];

    // masking with the registered ready keeps the pulse one cycle long
    assign ram_ready    = ram_en && !cpu_mem_ready;
    assign periph_ready = ((vdp_en && vdp_ready) || pad_en) && !cpu_mem_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cpu_mem_ready <= 1'b0;
            flash_en_q    <= 1'b0;
        end else begin
            // cpu stalls for the whole dma burst
            cpu_mem_ready <= !dma_busy &&
                             (ram_ready || flash_read_ready || periph_ready);
            // aligns the flash select with the flash data
            flash_en_q    <= flash_read_en;
        end
    end

    // read data select, ram by default
    always_comb begin
        cpu_read_data = ram_read_data;
        if (flash_en_q) begin
            cpu_read_data = flash_read_data;
        end else if (vdp_en) begin
            // 16 bit register seen on both halves
            cpu_read_data = {2{vdp_read_data}};
        end else if (pad_en) begin
            cpu_read_data[pad_w-1:0] = pad_read_data;
        end
    end

endmodule

/* src/addr_decoder.sv */
//*********************************************************************
// Address decoder
// turns a valid CPU access into one-hot region enables
//*********************************************************************
`timescale 1ns/1ps

module addr_decoder (
    input  logic               cpu_valid,
    input  bus_pkg::cpu_addr_t cpu_address,
    output logic               ram_en,
    output logic               flash_read_en,
    output logic               vdp_en,
    output logic               pad_en
);
    import map_pkg::*;

    region_t region;
    logic    io_pad_sel;

    // top two address bits pick the region
    assign region     = cpu_address[15:14];
    assign io_pad_sel = cpu_address[13];

    // every enable gated by valid, regions are disjoint
    assign ram_en        = cpu_valid && (region[1] == region_ram[1]);
    assign flash_read_en = cpu_valid && (region == region_flash);

    // io region split on bit 13
    assign vdp_en = cpu_valid && (region == region_io) && !io_pad_sel;
    assign pad_en = cpu_valid && (region == region_io) && io_pad_sel;

endmodule

/* src/map_pkg.sv */
//*********************************************************************
// Memory map package
// region codes, flash timing and contents, video register count,
// DMA state encoding
//*********************************************************************
package map_pkg;

    // region code is byte address bits 15:14
    typedef logic [1:0] region_t;

    // ram spans codes 0 and 1, only the top bit is decoded
    localparam region_t region_ram   = 2'd0;
    localparam region_t region_flash = 2'd2;
    // io: bit 13 clear is video, set is pad
    localparam region_t region_io    = 2'd3;

    // flash enable to flash ready, in cycles
    localparam int flash_wait  = 3;
    localparam int flash_cnt_w = $clog2(flash_wait + 1);
    localparam logic [31:0] flash_pattern = 32'hA5A5_0000;

    localparam int vdp_reg_count = 4;
    localparam int vdp_sel_w     = $clog2(vdp_reg_count);

    typedef enum logic {
        dma_idle,
        dma_run
    } dma_state_t;

endpackage

/* src/bus_pkg.sv */
//*********************************************************************
// Bus package
// widths and vector types shared by the CPU, RAM and DMA buses
//*********************************************************************
package bus_pkg;

    // cpu side
    localparam int cpu_addr_w = 16;
    localparam int data_w     = 32;
    localparam int wstrb_w    = data_w / 8;

    // ram is word addressed, byte address bits 15:2
    localparam int ram_addr_w = cpu_addr_w - 2;
    localparam int ram_words  = 1 << ram_addr_w;

    // peripherals
    localparam int vdp_data_w = 16;
    localparam int pad_w      = 2;

    // dma word count
    localparam int dma_len_w  = 8;

    typedef logic [cpu_addr_w-1:0] cpu_addr_t;
    typedef logic [ram_addr_w-1:0] ram_addr_t;
    typedef logic [data_w-1:0]     data_t;
    typedef logic [wstrb_w-1:0]    wstrb_t;
    typedef logic [vdp_data_w-1:0] vdp_data_t;
    typedef logic [pad_w-1:0]      pad_t;
    typedef logic [dma_len_w-1:0]  dma_len_t;

endpackage
